// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = bulls_cows_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/bulls_cows_scorer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_scorer (
    input  wire         clk,
    input  wire         rst_n_one_pulse,
    input  wire         score_req,
    input  wire  [15:0] secret,
    input  wire  [15:0] guess,
    output logic [2:0]  bulls,
    output logic [2:0]  cows
);

    import game_pkg::*;

    logic [COUNT_W-1:0] bulls_next;
    logic [COUNT_W-1:0] cows_next;
    logic [NUM_DIGITS-1:0] hit;  // guess digit found elsewhere in the secret

    always_comb begin
        bulls_next = '0;
        cows_next  = '0;
        hit        = '0;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (guess[i*DIGIT_W +: DIGIT_W] == secret[i*DIGIT_W +: DIGIT_W]) begin
                bulls_next = bulls_next + 1'b1;
            end else begin
                for (int j = 0; j < NUM_DIGITS; j++) begin
                    if (j != i &&
                        guess[i*DIGIT_W +: DIGIT_W] == secret[j*DIGIT_W +: DIGIT_W]) begin
                        hit[i] = 1'b1;
                    end
                end
                if (hit[i]) cows_next = cows_next + 1'b1;  // secret digits are distinct
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_one_pulse) begin
            bulls <= '0;
            cows  <= '0;
        end else if (score_req) begin
            bulls <= bulls_next;
            cows  <= cows_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bulls_cows_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_top #(
    parameter int DEBOUNCE_LEN = 4,
    parameter int SCAN_DIV_W   = 17
) (
    input  wire         clk,
    input  wire         rst_n_one_pulse,
    input  wire         start,
    input  wire         enter,
    input  wire  [3:0]  sw,
    output logic [7:0]  seg,
    output logic [3:0]  an,
    output logic [15:0] light
);

    import game_pkg::*;

    logic        start_pulse;
    logic        enter_pulse;
    logic        gen_req;
    logic [15:0] secret;
    logic        secret_valid;
    game_state_t state;
    logic [15:0] guess;
    logic [2:0]  digits_entered;
    logic        score_req;
    logic [2:0]  bulls;
    logic [2:0]  cows;

    // ====================
    // buttons
    // ====================
    button_conditioner #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) start_cond_i (
        .clk             (clk),
        .rst_n_one_pulse (rst_n_one_pulse),
        .button          (start),
        .pulse           (start_pulse)
    );

    button_conditioner #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) enter_cond_i (
        .clk             (clk),
        .rst_n_one_pulse (rst_n_one_pulse),
        .button          (enter),
        .pulse           (enter_pulse)
    );

    // ====================
    // game core
    // ====================
    secret_generator secret_generator_i (
        .clk             (clk),
        .rst_n_one_pulse (rst_n_one_pulse),
        .gen_req         (gen_req),
        .secret          (secret),
        .secret_valid    (secret_valid)
    );

    guess_game_fsm guess_game_fsm_i (
        .clk             (clk),
        .rst_n_one_pulse (rst_n_one_pulse),
        .start_pulse     (start_pulse),
        .enter_pulse     (enter_pulse),
        .sw              (sw),
        .secret_valid    (secret_valid),
        .gen_req         (gen_req),
        .state           (state),
        .guess           (guess),
        .digits_entered  (digits_entered),
        .score_req       (score_req)
    );

    bulls_cows_scorer bulls_cows_scorer_i (
        .clk             (clk),
        .rst_n_one_pulse (rst_n_one_pulse),
        .score_req       (score_req),
        .secret          (secret),
        .guess           (guess),
        .bulls           (bulls),
        .cows            (cows)
    );

    seg_display_scan #(.SCAN_DIV_W(SCAN_DIV_W)) seg_display_scan_i (
        .clk             (clk),
        .rst_n_one_pulse (rst_n_one_pulse),
        .state           (state),
        .guess           (guess),
        .digits_entered  (digits_entered),
        .bulls           (bulls),
        .cows            (cows),
        .seg             (seg),
        .an              (an)
    );

    // secret on the leds outside idle
    always_ff @(posedge clk) begin
        if (!rst_n_one_pulse) begin
            light <= '0;
        end else begin
            light <= (state == IDLE) ? 16'd0 : secret;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/button_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_conditioner #(
    parameter int DEBOUNCE_LEN = 4
) (
    input  wire  clk,
    input  wire  rst_n_one_pulse,
    input  wire  button,
    output logic pulse
);

    logic [DEBOUNCE_LEN-1:0] history;
    logic                    stable;
    logic                    stable_d;

    // high only once every sample in the window agrees
    assign stable = &history;

    always_ff @(posedge clk) begin
        if (!rst_n_one_pulse) begin
            history  <= '0;
            stable_d <= 1'b0;
            pulse    <= 1'b0;
        end else begin
            history  <= {history[DEBOUNCE_LEN-2:0], button};
            stable_d <= stable;
            pulse    <= stable & ~stable_d;  // rising edge of the clean level
        end
    end

endmodule

`default_nettype wire

// ==== rtl/game_pkg.sv ====
`default_nettype none

package game_pkg;

    localparam int DIGIT_W    = 4;
    localparam int NUM_DIGITS = 4;
    localparam int COUNT_W    = 3;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        GENERATE = 2'd1,
        GUESSING = 2'd2,
        RESULT   = 2'd3
    } game_state_t;

    // ====================
    // seven-segment codes, active low, a..g then dp
    // ====================
    localparam logic [7:0] SEG_BLANK  = 8'b11111111;
    localparam logic [7:0] SEG_A_CHAR = 8'b00010001;
    localparam logic [7:0] SEG_B_CHAR = 8'b11000001;  // lower case b

    function automatic logic [7:0] seg_digit(input logic [DIGIT_W-1:0] d);
        logic [7:0] pattern;
        case (d)
            4'd0:    pattern = 8'b00000011;
            4'd1:    pattern = 8'b10011111;
            4'd2:    pattern = 8'b00100101;
            4'd3:    pattern = 8'b00001101;
            4'd4:    pattern = 8'b10011001;
            4'd5:    pattern = 8'b01001001;
            4'd6:    pattern = 8'b01000001;
            4'd7:    pattern = 8'b00011111;
            4'd8:    pattern = 8'b00000001;
            4'd9:    pattern = 8'b00001001;
            default: pattern = SEG_BLANK;  // not a decimal digit
        endcase
        return pattern;
    endfunction

    localparam logic [7:0] LFSR_SEED = 8'hBD;

endpackage

`default_nettype wire

// ==== rtl/guess_game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module guess_game_fsm (
    input  wire                   clk,
    input  wire                   rst_n_one_pulse,
    input  wire                   start_pulse,
    input  wire                   enter_pulse,
    input  wire  [3:0]            sw,
    input  wire                   secret_valid,
    output logic                  gen_req,
    output game_pkg::game_state_t state,
    output logic [15:0]           guess,
    output logic [2:0]            digits_entered,
    output logic                  score_req
);

    import game_pkg::*;

    logic take_digit;
    logic new_round;
    logic last_digit;

    assign take_digit = (state == GUESSING) && enter_pulse;
    assign last_digit = (digits_entered == 3'(NUM_DIGITS - 1));

    // every way into GUESSING starts an empty guess
    assign new_round = ((state == GENERATE) && secret_valid) ||
                       ((state == RESULT) && enter_pulse && !start_pulse);

    // ====================
    // state and strobes
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n_one_pulse) begin
            state          <= IDLE;
            digits_entered <= '0;
            gen_req        <= 1'b0;
            score_req      <= 1'b0;
        end else begin
            gen_req   <= 1'b0;
            score_req <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_pulse) begin
                        gen_req <= 1'b1;
                        state   <= GENERATE;
                    end
                end
                GENERATE: begin
                    if (secret_valid) begin
                        state          <= GUESSING;
                        digits_entered <= '0;
                    end
                end
                GUESSING: begin
                    if (enter_pulse) begin
                        digits_entered <= digits_entered + 3'd1;
                        if (last_digit) begin
                            state     <= RESULT;
                            score_req <= 1'b1;  // guess is complete on the same edge
                        end
                    end
                end
                RESULT: begin
                    if (start_pulse) begin
                        state <= IDLE;
                    end else if (enter_pulse) begin
                        state          <= GUESSING;
                        digits_entered <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ====================
    // guess shift register
    // ====================
    always_ff @(posedge clk) begin
        if (new_round) begin
            guess <= '0;
        end else if (take_digit) begin
            guess <= {guess[(NUM_DIGITS-1)*DIGIT_W-1:0], sw};  // newest digit lowest
        end
    end

endmodule

`default_nettype wire

// ==== rtl/secret_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module secret_generator (
    input  wire         clk,
    input  wire         rst_n_one_pulse,
    input  wire         gen_req,
    output logic [15:0] secret,
    output logic        secret_valid
);

    import game_pkg::*;

    logic [7:0]                           lfsr;
    logic [7:0]                           lfsr_next;
    logic                                 busy;
    logic [$clog2(NUM_DIGITS)-1:0]        taken;     // digits collected so far
    logic [9:0]                           used;      // one bit per decimal digit
    logic [(NUM_DIGITS-1)*DIGIT_W-1:0]    collect;
    logic [DIGIT_W-1:0]                   nib;
    logic                                 nib_ok;

    // galois form, taps into bits 2, 3 and 4
    assign lfsr_next = {lfsr[6:4], lfsr[3] ^ lfsr[7], lfsr[2] ^ lfsr[7],
                        lfsr[1] ^ lfsr[7], lfsr[0], lfsr[7]};

    assign nib    = lfsr[DIGIT_W-1:0];
    assign nib_ok = (nib < 4'd10) && !used[nib];

    always_ff @(posedge clk) begin
        if (!rst_n_one_pulse) begin
            lfsr         <= LFSR_SEED;
            busy         <= 1'b0;
            taken        <= '0;
            secret       <= '0;
            secret_valid <= 1'b0;
        end else begin
            lfsr         <= lfsr_next;
            secret_valid <= 1'b0;
            if (gen_req) begin
                busy  <= 1'b1;
                taken <= '0;
                used  <= '0;
            end else if (busy && nib_ok) begin
                used[nib] <= 1'b1;
                if (taken == NUM_DIGITS - 1) begin
                    // first digit ends up in the top nibble
                    secret       <= {collect, nib};
                    secret_valid <= 1'b1;
                    busy         <= 1'b0;
                end else begin
                    collect <= {collect[(NUM_DIGITS-2)*DIGIT_W-1:0], nib};
                    taken   <= taken + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/seg_display_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg_display_scan #(
    parameter int SCAN_DIV_W = 17
) (
    input  wire                   clk,
    input  wire                   rst_n_one_pulse,
    input  game_pkg::game_state_t state,
    input  wire  [15:0]           guess,
    input  wire  [2:0]            digits_entered,
    input  wire  [2:0]            bulls,
    input  wire  [2:0]            cows,
    output logic [7:0]            seg,
    output logic [3:0]            an
);

    import game_pkg::*;

    logic [SCAN_DIV_W-1:0] scan_cnt;
    logic                  tick;
    logic [1:0]            pos;       // 0 is the rightmost digit
    logic [7:0]            seg_next;

    assign tick = &scan_cnt;

    // ====================
    // what each position shows
    // ====================
    always_comb begin
        seg_next = SEG_BLANK;
        case (state)
            GUESSING: begin
                // digits fill in from the right
                if ({1'b0, pos} < digits_entered) begin
                    seg_next = seg_digit(guess[pos*DIGIT_W +: DIGIT_W]);
                end
            end
            RESULT: begin
                case (pos)
                    2'd3:    seg_next = SEG_A_CHAR;
                    2'd2:    seg_next = seg_digit(DIGIT_W'(bulls));
                    2'd1:    seg_next = SEG_B_CHAR;
                    default: seg_next = seg_digit(DIGIT_W'(cows));
                endcase
            end
            default: begin  // idle banner b2A1
                case (pos)
                    2'd3:    seg_next = SEG_B_CHAR;
                    2'd2:    seg_next = seg_digit(4'd2);
                    2'd1:    seg_next = SEG_A_CHAR;
                    default: seg_next = seg_digit(4'd1);
                endcase
            end
        endcase
    end

    // ====================
    // scan
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n_one_pulse) begin
            scan_cnt <= '0;
            pos      <= '0;
            an       <= 4'b1111;
            seg      <= SEG_BLANK;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            if (tick) begin
                an  <= ~(4'b0001 << pos);
                seg <= seg_next;
                pos <= pos + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/game_pkg.sv
rtl/button_conditioner.sv
rtl/secret_generator.sv
rtl/guess_game_fsm.sv
rtl/bulls_cows_scorer.sv
rtl/seg_display_scan.sv
rtl/bulls_cows_top.sv
verif/bulls_cows_tb.sv

// ==== verif/bulls_cows_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bulls_cows_tb;

    import game_pkg::*;

    localparam int DEBOUNCE_LEN = 4;
    localparam int SCAN_DIV_W   = 3;
    localparam int HOLD_CYCLES  = DEBOUNCE_LEN + 3;

    // row kinds are built from the secret once it is known
    localparam int ROW_EXACT  = 0;
    localparam int ROW_ROTATE = 1;
    localparam int ROW_NONE   = 2;
    localparam int ROW_MIXED  = 3;
    localparam int ROW_RANDOM = 4;

    localparam int NUM_ROWS          = 5;
    localparam int PRESS_CYCLES      = 200;
    localparam int GEN_MARGIN_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES    =
        (NUM_ROWS * (NUM_DIGITS + 1) + 4) * PRESS_CYCLES + GEN_MARGIN_CYCLES;

    // ====================
    // stimulus table
    // ====================
    int row_kind  [NUM_ROWS] = '{ROW_EXACT, ROW_ROTATE, ROW_NONE, ROW_MIXED, ROW_RANDOM};
    int row_bulls [NUM_ROWS] = '{4, 0, 0, 1, -1};  // -1 takes the reference scorer
    int row_cows  [NUM_ROWS] = '{0, 4, 0, 2, -1};

    logic        clk;
    logic        rst_n_one_pulse;
    logic        start;
    logic        enter;
    logic [3:0]  sw;
    logic [7:0]  seg;
    logic [3:0]  an;
    logic [15:0] light;

    logic [7:0]  shown [0:3];  // seg seen per position with 0 on the right
    logic [7:0]  want  [0:3];
    int          seed = 32'hde2f;

    bulls_cows_top #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN),
        .SCAN_DIV_W   (SCAN_DIV_W)
    ) bulls_cows_top_i (
        .clk             (clk),
        .rst_n_one_pulse (rst_n_one_pulse),
        .start           (start),
        .enter           (enter),
        .sw              (sw),
        .seg             (seg),
        .an              (an),
        .light           (light)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    task automatic press(input logic is_enter);
        @(posedge clk);
        if (is_enter) enter <= 1'b1;
        else          start <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        enter <= 1'b0;
        start <= 1'b0;
        repeat (HOLD_CYCLES) @(posedge clk);
    endtask

    // two full sweeps since the first may still hold old values
    task automatic read_display();
        logic [3:0] seen;
        int         p;
        for (int sweep = 0; sweep < 2; sweep++) begin
            seen = 4'b0000;
            while (seen != 4'b1111) begin
                @(negedge clk);
                for (p = 0; p < 4; p++) begin
                    if (an == ~(4'b0001 << p)) begin
                        seen[p]  = 1'b1;
                        shown[p] = seg;
                    end
                end
            end
        end
    endtask

    task automatic compare_display();
        read_display();
        for (int p = 0; p < 4; p++) begin
            check_value($sformatf("seg at position %0d", p), 16'(shown[p]), 16'(want[p]));
        end
    endtask

    task automatic expect_display(input logic [7:0] e3, input logic [7:0] e2,
                                  input logic [7:0] e1, input logic [7:0] e0);
        want[3] = e3;
        want[2] = e2;
        want[1] = e1;
        want[0] = e0;
        compare_display();
    endtask

    // reference scorer returning {bulls, cows}
    function automatic logic [5:0] score_ref(input logic [15:0] sec, input logic [15:0] gs);
        int         b;
        int         c;
        logic       found;
        logic [3:0] gd;
        b = 0;
        c = 0;
        for (int i = 0; i < 4; i++) begin
            gd = gs[i*4 +: 4];
            if (gd == sec[i*4 +: 4]) begin
                b++;
            end else begin
                found = 1'b0;
                for (int j = 0; j < 4; j++) begin
                    if (j != i && gd == sec[j*4 +: 4]) found = 1'b1;
                end
                if (found) c++;
            end
        end
        return {3'(b), 3'(c)};
    endfunction

    function automatic logic [15:0] make_guess(input int kind, input logic [15:0] sec,
                                               input logic [15:0] spare,
                                               input logic [15:0] rnd);
        case (kind)
            ROW_EXACT:  return sec;
            ROW_ROTATE: return {sec[11:0], sec[15:12]};  // every digit moves
            ROW_NONE:   return spare;
            ROW_MIXED:  return {sec[15:12], sec[7:4], sec[11:8], spare[3:0]};
            default:    return rnd;
        endcase
    endfunction

    // ====================
    // watchdog
    // ====================
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [15:0] secret;
        logic [15:0] spare;
        logic [15:0] rnd;
        logic [15:0] gval;
        logic [5:0]  ref_score;
        logic [2:0]  exp_b;
        logic [2:0]  exp_c;
        int          n;

        rst_n_one_pulse <= 1'b0;
        start           <= 1'b0;
        enter           <= 1'b0;
        sw              <= 4'd0;
        repeat (4) @(posedge clk);
        rst_n_one_pulse <= 1'b1;

        for (int i = 0; i < 4; i++) begin
            rnd[i*4 +: 4] = 4'($unsigned($random(seed)) % 10);
        end

        // idle banner
        @(negedge clk);
        check_value("light", light, 16'h0000);
        check_value("an", 16'(an), 16'h000f);
        expect_display(SEG_B_CHAR, seg_digit(4'd2), SEG_A_CHAR, seg_digit(4'd1));

        press(1'b0);
        while (light == 16'h0000) @(negedge clk);
        secret = light;
        for (int i = 0; i < 4; i++) begin
            if (secret[i*4 +: 4] > 4'd9) fail_run("secret digit above 9");
            for (int j = i + 1; j < 4; j++) begin
                if (secret[i*4 +: 4] == secret[j*4 +: 4]) fail_run("secret digits repeat");
            end
        end

        // first four digits that the secret does not use
        n = 0;
        spare = '0;
        for (int d = 0; d < 10; d++) begin
            if (n < 4 && secret[15:12] != d && secret[11:8] != d &&
                secret[7:4] != d && secret[3:0] != d) begin
                spare = {spare[11:0], 4'(d)};
                n++;
            end
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            gval = make_guess(row_kind[r], secret, spare, rnd);
            if (r > 0) press(1'b1);  // back to guessing
            expect_display(SEG_BLANK, SEG_BLANK, SEG_BLANK, SEG_BLANK);
            for (int k = 1; k <= 4; k++) begin
                @(posedge clk);
                sw <= gval[(4-k)*4 +: 4];
                press(1'b1);
                if (k < 4) begin
                    for (int p = 0; p < 4; p++) begin
                        want[p] = (p < k) ? seg_digit(gval[(4-k+p)*4 +: 4]) : SEG_BLANK;
                    end
                    compare_display();
                end
            end
            ref_score = score_ref(secret, gval);
            if (row_bulls[r] >= 0) begin
                check_value("reference bulls", 16'(ref_score[5:3]), 16'(row_bulls[r]));
                check_value("reference cows", 16'(ref_score[2:0]), 16'(row_cows[r]));
            end
            exp_b = (row_bulls[r] < 0) ? ref_score[5:3] : 3'(row_bulls[r]);
            exp_c = (row_cows[r] < 0)  ? ref_score[2:0] : 3'(row_cows[r]);
            expect_display(SEG_A_CHAR, seg_digit(4'(exp_b)), SEG_B_CHAR, seg_digit(4'(exp_c)));
        end

        // start from result goes back to idle
        press(1'b0);
        @(negedge clk);
        check_value("light", light, 16'h0000);
        expect_display(SEG_B_CHAR, seg_digit(4'd2), SEG_A_CHAR, seg_digit(4'd1));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
